/* design/neoPalPkg.sv */
package neoPalPkg;

	// Palette index within one bank
	localparam int palAddrW = 12;
	// Palette word width
	localparam int palDataW = 16;
	// Output level per channel
	localparam int colorW = 7;
	// Two banks of 4096 words
	localparam int palDepth = 2 ** (palAddrW + 1);

	// Master cycles per pixel slot
	localparam int slotPhases = 4;
	localparam int phaseW = $clog2(slotPhases);
	// Video read slot, also the pixel tick
	localparam logic [phaseW-1:0] vidPhase = phaseW'(0);
	// CPU access slot
	localparam logic [phaseW-1:0] cpuPhase = phaseW'(2);

	// System latch index, from address bits 3 to 1
	localparam int latchIdxW = 3;
	localparam logic [latchIdxW-1:0] shadowIdx = 3'd0;
	localparam logic [latchIdxW-1:0] palBnkIdx = 3'd7;

	// Slot sequencer states
	localparam int seqStateW = 2;
	localparam logic [seqStateW-1:0] seqIdle = 2'd0;
	localparam logic [seqStateW-1:0] seqCpuPending = 2'd1;
	localparam logic [seqStateW-1:0] seqCpuReturn = 2'd2;

	// Palette word as seen by the video side
	typedef struct packed {
		logic dark;
		logic rLsb;
		logic gLsb;
		logic bLsb;
		logic [3:0] r4;
		logic [3:0] g4;
		logic [3:0] b4;
	} palColor;

	// Raw for the CPU, colour fields for the video output
	typedef union packed {
		logic [palDataW-1:0] raw;
		palColor color;
	} palWord;

endpackage

/* design/palBusIf.sv */
`timescale 1ns/1ns

interface palBusIf;

	// Bank bit on top of the 12-bit index
	logic [neoPalPkg::palAddrW:0] addr;
	neoPalPkg::palWord wrData;
	// One-cycle strobes, never both at once
	logic we;
	logic re;
	// Valid the cycle after re
	neoPalPkg::palWord rdData;

	// Slot sequencer side
	modport requester (
		output addr,
		output wrData,
		output we,
		output re,
		input rdData
	);

	// Palette RAM side
	modport memory (
		input addr,
		input wrData,
		input we,
		input re,
		output rdData
	);

endinterface

/* design/pixelTimer.sv */
`timescale 1ns/1ns

module pixelTimer (
	input logic clk24M,
	input logic rstN,
	output logic [neoPalPkg::phaseW-1:0] phase,
	output logic pixTick
);

	// Free-running slot phase, 0 to 3
	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			phase <= '0;
		end else if (phase == neoPalPkg::phaseW'(neoPalPkg::slotPhases - 1)) begin
			// Wrap at end of the slot
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// Tick marks the video read phase and stays low in reset
	assign pixTick = rstN && (phase == neoPalPkg::vidPhase);

endmodule

/* design/palSlotSequencer.sv */
`timescale 1ns/1ns

module palSlotSequencer (
	input logic clk24M,
	input logic rstN,
	input logic [neoPalPkg::phaseW-1:0] phase,
	input logic [neoPalPkg::palAddrW-1:0] cpuAddr,
	input logic [neoPalPkg::palDataW-1:0] cpuWrData,
	input logic cpuWe,
	input logic cpuRe,
	input logic palBnk,
	input logic [neoPalPkg::palAddrW-1:0] pixIndex,
	palBusIf.requester ram,
	output logic [neoPalPkg::palDataW-1:0] cpuRdData,
	output logic cpuRdValid,
	output logic vidFetch
);

	logic [neoPalPkg::seqStateW-1:0] state;
	logic [neoPalPkg::seqStateW-1:0] stateNext;

	// Captured CPU access
	logic [neoPalPkg::palAddrW-1:0] pendAddr;
	logic [neoPalPkg::palDataW-1:0] pendData;
	logic pendWrite;

	logic isPending;
	logic newReq;
	logic reqValid;
	logic reqWrite;
	logic [neoPalPkg::palAddrW-1:0] reqAddr;
	logic [neoPalPkg::palDataW-1:0] reqData;
	logic cpuSlot;

	assign isPending = (state == neoPalPkg::seqCpuPending);
	// Strobes while pending are dropped
	assign newReq = !isPending && (cpuWe || cpuRe);

	// Pending access first, else a strobe arriving this cycle
	assign reqValid = isPending || newReq;
	assign reqAddr = isPending ? pendAddr : cpuAddr;
	assign reqData = isPending ? pendData : cpuWrData;
	// Write wins if both strobes come together
	assign reqWrite = isPending ? pendWrite : cpuWe;

	assign vidFetch = (phase == neoPalPkg::vidPhase);
	assign cpuSlot = (phase == neoPalPkg::cpuPhase) && reqValid;

	// RAM port, video by default, CPU in its slot
	always_comb begin
		ram.addr = {palBnk, pixIndex};
		ram.wrData.raw = reqData;
		ram.we = 1'b0;
		ram.re = vidFetch;
		if (cpuSlot) begin
			ram.addr = {palBnk, reqAddr};
			ram.we = reqWrite;
			ram.re = !reqWrite;
		end
	end

	always_comb begin
		stateNext = state;
		case (state)
			neoPalPkg::seqCpuPending: begin
				if (cpuSlot) begin
					stateNext = reqWrite ? neoPalPkg::seqIdle : neoPalPkg::seqCpuReturn;
				end
			end
			default: begin
				// Idle or return; a strobe at phase 2 goes straight out
				if (cpuSlot) begin
					stateNext = reqWrite ? neoPalPkg::seqIdle : neoPalPkg::seqCpuReturn;
				end else if (newReq) begin
					stateNext = neoPalPkg::seqCpuPending;
				end else begin
					stateNext = neoPalPkg::seqIdle;
				end
			end
		endcase
	end

	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			state <= neoPalPkg::seqIdle;
		end else begin
			state <= stateNext;
		end
	end

	// Hold the access until its slot
	always_ff @(posedge clk24M) begin
		if (newReq && !cpuSlot) begin
			pendAddr <= cpuAddr;
			pendData <= cpuWrData;
			pendWrite <= cpuWe;
		end
	end

	// Read word arrives one cycle after the CPU slot
	assign cpuRdValid = (state == neoPalPkg::seqCpuReturn);
	assign cpuRdData = ram.rdData.raw;

endmodule

/* design/sysLatch.sv */
`timescale 1ns/1ns

module sysLatch (
	input logic clk24M,
	input logic rstN,
	input logic latchWe,
	input logic [4:1] latchAddr,
	output logic shadow,
	output logic palBnk
);

	logic [neoPalPkg::latchIdxW-1:0] latchIdx;
	logic latchVal;

	// Address bits 3 to 1 pick the bit, bit 4 is the value
	assign latchIdx = latchAddr[3:1];
	assign latchVal = latchAddr[4];

	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			shadow <= 1'b0;
			palBnk <= 1'b0;
		end else if (latchWe) begin
			// Shadow dims the output
			if (latchIdx == neoPalPkg::shadowIdx) begin
				shadow <= latchVal;
			end
			// Bank select for CPU and video
			if (latchIdx == neoPalPkg::palBnkIdx) begin
				palBnk <= latchVal;
			end
			// Other indices belong to absent latch bits
		end
	end

endmodule

/* design/palRam.sv */
`timescale 1ns/1ns

module palRam (
	input logic clk24M,
	palBusIf.memory ram
);

	// Two banks, bank bit is the address msb
	neoPalPkg::palWord mem [0:neoPalPkg::palDepth-1];

	// Write port
	always_ff @(posedge clk24M) begin
		if (ram.we) begin
			mem[ram.addr] <= ram.wrData;
		end
	end

	// Registered read, word holds until the next re
	always_ff @(posedge clk24M) begin
		if (ram.re) begin
			ram.rdData <= mem[ram.addr];
		end
	end

endmodule

/* design/videoOut.sv */
`timescale 1ns/1ns

module videoOut (
	input logic clk24M,
	input logic rstN,
	input logic vidFetch,
	input logic pixBlank,
	input logic shadow,
	input neoPalPkg::palWord palData,
	output logic [neoPalPkg::colorW-1:0] videoR,
	output logic [neoPalPkg::colorW-1:0] videoG,
	output logic [neoPalPkg::colorW-1:0] videoB,
	output logic rgbValid
);

	// Fetch strobe and blank lined up with palData
	logic fetchD;
	logic blankD;

	// 5-bit channel value times 4, dark step, then shadow
	function automatic logic [neoPalPkg::colorW-1:0] level(
		input logic [3:0] c4,
		input logic lsb,
		input logic dark,
		input logic shade
	);
		logic [neoPalPkg::colorW-1:0] lvl;
		lvl = {c4, lsb, 2'b00};
		if (!dark) begin
			lvl = lvl + neoPalPkg::colorW'(2);
		end
		// Halve, rounding down
		if (shade) begin
			lvl = lvl >> 1;
		end
		return lvl;
	endfunction

	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			fetchD <= 1'b0;
			blankD <= 1'b0;
			rgbValid <= 1'b0;
			videoR <= '0;
			videoG <= '0;
			videoB <= '0;
		end else begin
			fetchD <= vidFetch;
			blankD <= pixBlank;
			rgbValid <= fetchD;
			// Levels change only on a fetched word
			if (fetchD) begin
				if (blankD) begin
					videoR <= '0;
					videoG <= '0;
					videoB <= '0;
				end else begin
					videoR <= level(palData.color.r4, palData.color.rLsb,
						palData.color.dark, shadow);
					videoG <= level(palData.color.g4, palData.color.gLsb,
						palData.color.dark, shadow);
					videoB <= level(palData.color.b4, palData.color.bLsb,
						palData.color.dark, shadow);
				end
			end
		end
	end

endmodule

/* design/neoPalette.sv */
`timescale 1ns/1ns

module neoPalette (
	input logic clk24M,
	input logic rstN,
	// 68K side
	input logic [neoPalPkg::palAddrW-1:0] cpuAddr,
	input logic [neoPalPkg::palDataW-1:0] cpuWrData,
	input logic cpuWe,
	input logic cpuRe,
	input logic latchWe,
	input logic [4:1] latchAddr,
	// Pixel index from the layer logic
	input logic [neoPalPkg::palAddrW-1:0] pixIndex,
	input logic pixBlank,
	output logic [neoPalPkg::palDataW-1:0] cpuRdData,
	output logic cpuRdValid,
	output logic pixTick,
	output logic [neoPalPkg::colorW-1:0] videoR,
	output logic [neoPalPkg::colorW-1:0] videoG,
	output logic [neoPalPkg::colorW-1:0] videoB,
	output logic rgbValid
);

	logic [neoPalPkg::phaseW-1:0] phase;
	logic shadow;
	logic palBnk;
	logic vidFetch;

	// Palette RAM port
	palBusIf palBus ();

	// Slot timing
	pixelTimer u_pixelTimer (
		.clk24M (clk24M),
		.rstN (rstN),
		.phase (phase),
		.pixTick (pixTick)
	);

	// Shadow and bank bits
	sysLatch u_sysLatch (
		.clk24M (clk24M),
		.rstN (rstN),
		.latchWe (latchWe),
		.latchAddr (latchAddr),
		.shadow (shadow),
		.palBnk (palBnk)
	);

	palSlotSequencer u_palSlotSequencer (
		.clk24M (clk24M),
		.rstN (rstN),
		.phase (phase),
		.cpuAddr (cpuAddr),
		.cpuWrData (cpuWrData),
		.cpuWe (cpuWe),
		.cpuRe (cpuRe),
		.palBnk (palBnk),
		.pixIndex (pixIndex),
		.ram (palBus.requester),
		.cpuRdData (cpuRdData),
		.cpuRdValid (cpuRdValid),
		.vidFetch (vidFetch)
	);

	palRam u_palRam (
		.clk24M (clk24M),
		.ram (palBus.memory)
	);

	// Colour conversion
	videoOut u_videoOut (
		.clk24M (clk24M),
		.rstN (rstN),
		.vidFetch (vidFetch),
		.pixBlank (pixBlank),
		.shadow (shadow),
		.palData (palBus.rdData),
		.videoR (videoR),
		.videoG (videoG),
		.videoB (videoB),
		.rgbValid (rgbValid)
	);

endmodule

/* tests/neoPalette_assertions.sv */
`timescale 1ns/1ns

// Slot timing rules, bound into the palette top level
module neoPaletteAssertions (
	input logic clk24M,
	input logic rstN,
	input logic pixTick,
	input logic pixBlank,
	input logic rgbValid,
	input logic cpuRe,
	input logic cpuRdValid,
	input logic [neoPalPkg::colorW-1:0] videoR,
	input logic [neoPalPkg::colorW-1:0] videoG,
	input logic [neoPalPkg::colorW-1:0] videoB
);

	// Count of failed assertions
	int failCount = 0;

	// Pixel out two cycles after its tick
	assert property (@(posedge clk24M) disable iff (!rstN) pixTick |-> ##2 rgbValid)
		else begin
			$error("rgbValid missing two cycles after pixTick");
			failCount++;
		end

	// Never a pixel without a tick
	assert property (@(posedge clk24M) disable iff (!rstN) rgbValid |-> $past(pixTick, 2))
		else begin
			$error("rgbValid raised without a pixTick two cycles before");
			failCount++;
		end

	// Read word within one slot
	assert property (@(posedge clk24M) disable iff (!rstN) cpuRe |-> ##[1:4] cpuRdValid)
		else begin
			$error("cpuRdValid missing within 4 cycles of cpuRe");
			failCount++;
		end

	// Blanked pixel comes out black
	assert property (@(posedge clk24M) disable iff (!rstN)
		pixTick && pixBlank |-> ##2 (videoR == '0 && videoG == '0 && videoB == '0))
		else begin
			$error("blanked pixel shows a nonzero level");
			failCount++;
		end

endmodule

bind neoPalette neoPaletteAssertions u_neoPaletteAssertions (.*);

/* tests/tbNeoPalette.sv */
`timescale 1ns/1ns

module tbNeoPalette;

	// Twice the summed test lengths
	localparam int cycleLimit = 2 * (150 + 600 + 300 + 1200 + 400 + 350);

	logic clk24M, rstN, cpuWe, cpuRe, latchWe, pixBlank;
	logic [11:0] cpuAddr, pixIndex;
	logic [15:0] cpuWrData, cpuRdData;
	logic [4:1] latchAddr;
	logic cpuRdValid, pixTick, rgbValid;
	logic [6:0] videoR, videoG, videoB;

	// Reference palette, latches and slot phase
	logic [15:0] refPal [0:8191];
	logic refKnown [0:8191];
	logic modelShadow, modelBnk, tickD1, tickD2;
	logic [1:0] tbPhase;
	// Word fetched at the last tick
	logic [15:0] fetchWord;
	logic fetchKnown, fetchBlank;
	// CPU access waiting for its slot
	logic pend, pendWrite;
	logic [11:0] pendAddr;
	logic [15:0] pendData;
	// Expected pixels {known, r, g, b} and read words {known, data}
	logic [21:0] expQ[$];
	logic [16:0] rdQ[$];
	logic [21:0] expPix;
	logic [16:0] expRd;
	// Indices the pixel driver picks from
	logic [11:0] pool[$];
	logic blankOn;
	int errCount, errAtStart, testsRun, testsBad, cycleCnt;

	neoPalette u_neoPalette (.*);

	always #2 clk24M = ~clk24M;

	// Channel level from the 5-bit value, dark step and shadow
	function automatic logic [6:0] expLevel(input logic [4:0] v5, input logic dark,
		input logic shade);
		int lvl;
		lvl = v5 * 4 + (dark ? 0 : 2);
		if (shade) lvl = lvl / 2;
		return lvl[6:0];
	endfunction

	// Word layout is dark, r/g/b lsb, then r4 g4 b4
	function automatic logic [20:0] expPixel(input logic [15:0] w, input logic blank,
		input logic shade);
		if (blank) return '0;
		return {expLevel({w[11:8], w[14]}, w[15], shade),
			expLevel({w[7:4], w[13]}, w[15], shade),
			expLevel({w[3:0], w[12]}, w[15], shade)};
	endfunction

	// Testbench checks plus failed bound assertions
	function automatic int totalErrors();
		return errCount + u_neoPalette.u_neoPaletteAssertions.failCount;
	endfunction

	task automatic reportMismatch(input string sigName, input logic [15:0] expVal,
		input logic [15:0] gotVal);
		$display("Fail at %0t: %s expected %0h, got %0h", $time, sigName, expVal, gotVal);
		errCount++;
	endtask

	// Called at a falling edge; strobes stay four cycles apart
	task automatic cpuWrite(input logic [11:0] addr, input logic [15:0] data);
		cpuAddr = addr;
		cpuWrData = data;
		cpuWe = 1'b1;
		@(negedge clk24M);
		cpuWe = 1'b0;
		repeat (3) @(negedge clk24M);
	endtask

	task automatic cpuRead(input logic [11:0] addr);
		int waitCnt;
		cpuAddr = addr;
		cpuRe = 1'b1;
		@(negedge clk24M);
		cpuRe = 1'b0;
		waitCnt = 0;
		while (!cpuRdValid && waitCnt < 8) begin
			@(negedge clk24M);
			waitCnt++;
		end
		if (!cpuRdValid) begin
			$display("Read of %0h at %0t returned no data within 8 cycles", addr, $time);
			errCount++;
		end
		repeat (3) @(negedge clk24M);
	endtask

	// Index in bits 3 to 1, value in bit 4
	task automatic latchWrite(input logic [2:0] idx, input logic val);
		latchAddr = {val, idx};
		latchWe = 1'b1;
		@(negedge clk24M);
		latchWe = 1'b0;
	endtask

	task automatic endTest(input string name);
		int errNow;
		errNow = totalErrors();
		testsRun++;
		if (errNow == errAtStart) begin
			$display("test %0d %s: ok", testsRun, name);
		end else begin
			testsBad++;
			$display("test %0d %s: %0d errors", testsRun, name, errNow - errAtStart);
		end
		errAtStart = errNow;
	endtask

	// Wait at a falling edge inside a given slot phase
	task automatic syncPhase(input int p);
		do @(negedge clk24M); while (!pixTick);
		repeat (p) @(negedge clk24M);
	endtask

	// Continuous pixel stream from written indices
	always @(negedge clk24M) begin
		if (rstN && pool.size() > 0) pixIndex = pool[$urandom % pool.size()];
		pixBlank = blankOn && ($urandom % 4 == 0);
	end

	// Reference model and checks, on values from before each edge
	always @(posedge clk24M) begin
		if (!rstN) begin
			assert (!pixTick) else reportMismatch("pixTick", 0, pixTick);
			assert (!rgbValid) else reportMismatch("rgbValid", 0, rgbValid);
			assert (!cpuRdValid) else reportMismatch("cpuRdValid", 0, cpuRdValid);
			{tbPhase, tickD1, tickD2, pend, modelShadow, modelBnk} = '0;
			expQ.delete();
			rdQ.delete();
		end else begin
			assert (pixTick == (tbPhase == 0))
				else reportMismatch("pixTick", tbPhase == 0, pixTick);
			assert (rgbValid == tickD2) else reportMismatch("rgbValid", tickD2, rgbValid);
			if (rgbValid && expQ.size() > 0) begin
				expPix = expQ.pop_front();
				if (expPix[21]) begin
					assert (videoR == expPix[20:14])
						else reportMismatch("videoR", expPix[20:14], videoR);
					assert (videoG == expPix[13:7])
						else reportMismatch("videoG", expPix[13:7], videoG);
					assert (videoB == expPix[6:0])
						else reportMismatch("videoB", expPix[6:0], videoB);
				end
			end
			if (cpuRdValid) begin
				if (rdQ.size() == 0) begin
					$display("cpuRdValid raised at %0t with no read pending", $time);
					errCount++;
				end else begin
					expRd = rdQ.pop_front();
					if (expRd[16]) begin
						assert (cpuRdData == expRd[15:0])
							else reportMismatch("cpuRdData", expRd[15:0], cpuRdData);
					end
				end
			end
			// Fetched word meets the shadow bit one cycle after its tick
			if (tickD1) begin
				expQ.push_back({fetchKnown || fetchBlank,
					expPixel(fetchWord, fetchBlank, modelShadow)});
			end
			if (pixTick) begin
				fetchWord = refPal[{modelBnk, pixIndex}];
				fetchKnown = refKnown[{modelBnk, pixIndex}];
				fetchBlank = pixBlank;
			end
			tickD2 = tickD1;
			tickD1 = pixTick;
			// Strobe held until phase 2, later strobes dropped
			if (!pend && (cpuWe || cpuRe)) begin
				{pend, pendWrite, pendAddr, pendData} = {1'b1, cpuWe, cpuAddr, cpuWrData};
			end
			if (pend && tbPhase == 2) begin
				if (pendWrite) begin
					refPal[{modelBnk, pendAddr}] = pendData;
					refKnown[{modelBnk, pendAddr}] = 1'b1;
				end else begin
					rdQ.push_back({refKnown[{modelBnk, pendAddr}], refPal[{modelBnk, pendAddr}]});
				end
				pend = 1'b0;
			end
			// Only indices 0 and 7 exist
			if (latchWe && latchAddr[3:1] == neoPalPkg::shadowIdx) modelShadow = latchAddr[4];
			if (latchWe && latchAddr[3:1] == neoPalPkg::palBnkIdx) modelBnk = latchAddr[4];
			tbPhase = tbPhase + 1'b1;
		end
	end

	always @(posedge clk24M) begin
		cycleCnt++;
		if (cycleCnt >= cycleLimit) begin
			$display("Timeout: run stopped after %0d cycles without finishing", cycleCnt);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		logic [11:0] a;
		void'($urandom(69387));
		{clk24M, rstN, cpuWe, cpuRe, latchWe, pixBlank, blankOn} = '0;
		{cpuAddr, cpuWrData, latchAddr, pixIndex} = '0;
		{errCount, errAtStart, testsRun, testsBad, cycleCnt} = '0;
		for (int i = 0; i < 8192; i++) refKnown[i] = 1'b0;
		repeat (10) @(negedge clk24M);
		rstN = 1'b1;
		// First pixels with both latch bits at reset value
		for (int i = 0; i < 4; i++) begin
			cpuWrite(i, $urandom);
			pool.push_back(i);
		end
		repeat (32) @(negedge clk24M);
		endTest("reset and first pixels");
		for (int i = 0; i < 24; i++) begin
			a = $urandom;
			cpuWrite(a, $urandom);
			cpuRead(a);
			pool.push_back(a);
		end
		endTest("cpu write and read back");
		repeat (160) @(negedge clk24M);
		endTest("video levels");
		latchWrite(neoPalPkg::shadowIdx, 1'b1);
		repeat (80) @(negedge clk24M);
		latchWrite(neoPalPkg::shadowIdx, 1'b0);
		latchWrite(neoPalPkg::palBnkIdx, 1'b1);
		foreach (pool[k]) begin
			cpuWrite(pool[k], $urandom);
			cpuRead(pool[k]);
		end
		repeat (80) @(negedge clk24M);
		// First bank must be untouched
		latchWrite(neoPalPkg::palBnkIdx, 1'b0);
		foreach (pool[k]) cpuRead(pool[k]);
		endTest("shadow and palette bank");
		blankOn = 1'b1;
		repeat (80) @(negedge clk24M);
		blankOn = 1'b0;
		for (int i = 1; i < 7; i++) latchWrite(i, 1'b1);
		repeat (40) @(negedge clk24M);
		for (int i = 0; i < 4; i++) cpuRead(pool[i]);
		endTest("blanking and unused latch bits");
		// One write and one read in every slot phase
		for (int p = 0; p < 4; p++) begin
			a = $urandom;
			syncPhase(p);
			cpuWrite(a, $urandom);
			pool.push_back(a);
			syncPhase(p);
			cpuRead(a);
		end
		repeat (40) @(negedge clk24M);
		endTest("cpu access at each phase");
		$display("%0d tests run, %0d with errors, %0d errors in total", testsRun, testsBad,
			totalErrors());
		if (totalErrors() == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* Bender.yml */
package:
  name: neo_palette

sources:
  - design/neoPalPkg.sv
  - design/palBusIf.sv
  - design/pixelTimer.sv
  - design/palSlotSequencer.sv
  - design/sysLatch.sv
  - design/palRam.sv
  - design/videoOut.sv
  - design/neoPalette.sv
  - target: test
    files:
      - tests/neoPalette_assertions.sv
      - tests/tbNeoPalette.sv

/* tb.f */
design/neoPalPkg.sv
design/palBusIf.sv
design/pixelTimer.sv
design/palSlotSequencer.sv
design/sysLatch.sv
design/palRam.sv
design/videoOut.sv
design/neoPalette.sv
tests/neoPalette_assertions.sv
tests/tbNeoPalette.sv
